//--- Makefile
VERILATOR  ?= verilator
TOP        := sbus_tb
FILELIST   := sbus.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(BUILD_DIR)

//--- logic/sbus_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side master, four-phase command and word handshakes
// bursts of 1..4 words, burst bit set when cmd_len > 1
// id 3 reads back as ready with rd low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sbus_master
    import sbus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      cmd_req,
    input  logic      cmd_write,
    input  slave_id_t cmd_slave,
    input  addr_t     cmd_addr,
    input  len_t      cmd_len,
    output logic      cmd_ack,
    output logic      word_req,
    input  logic      word_ack,
    input  word_t     wdata,
    output word_t     rdata,
    output logic      control,
    output logic      wd,
    output logic      valid,
    output logic      last,
    input  logic      rd0,
    input  logic      rd1,
    input  logic      rd2,
    input  logic      ready0,
    input  logic      ready1,
    input  logic      ready2
);

    master_state_t          state;
    bit_cnt_t               bit_cnt;
    len_t                   word_cnt;   // words finished so far
    len_t                   len_q;
    slave_id_t              id_q;
    logic                   write_q;
    frame_t                 frame_q;
    word_t                  data_q;     // shared by write and read words
    logic [SLAVE_COUNT-1:0] rd_vec;
    logic [SLAVE_COUNT-1:0] ready_vec;
    logic                   rd_sel;
    logic                   ready_sel;
    logic                   word_end;
    logic                   final_word;

    assign rd_vec    = {rd2, rd1, rd0};
    assign ready_vec = {ready2, ready1, ready0};

    // return path of the addressed slave
    always_comb begin
        rd_sel    = 1'b0;
        ready_sel = 1'b1;
        if (id_q < slave_id_t'(SLAVE_COUNT)) begin
            rd_sel    = rd_vec[id_q];
            ready_sel = ready_vec[id_q];
        end
    end

    assign word_end   = (bit_cnt == bit_cnt_t'(DATA_WIDTH - 1));
    assign final_word = (word_cnt == len_q - len_t'(1));

    assign control = (state == MS_FRAME) & frame_q[FRAME_LEN-1];
    assign valid   = (state == MS_WSHIFT) || (state == MS_RSHIFT);
    assign last    = valid & word_end & final_word;
    assign wd      = data_q[DATA_WIDTH-1];
    assign rdata   = data_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= MS_IDLE;
            cmd_ack  <= 1'b0;
            word_req <= 1'b0;
            bit_cnt  <= '0;
            word_cnt <= '0;
            len_q    <= '0;
            id_q     <= '0;
            write_q  <= 1'b0;
        end else begin
            case (state)
                MS_IDLE: begin
                    if (cmd_req) begin
                        id_q    <= cmd_slave;
                        write_q <= cmd_write;
                        len_q   <= cmd_len;
                        cmd_ack <= 1'b1;
                        state   <= MS_CMD_ACK;
                    end
                end
                MS_CMD_ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        bit_cnt <= '0;
                        state   <= MS_FRAME;
                    end
                end
                MS_FRAME: begin
                    bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    if (bit_cnt == bit_cnt_t'(FRAME_LEN - 1)) begin
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                        word_req <= write_q;   // writes fetch the first word now
                        state    <= write_q ? MS_WORD_REQ : MS_WAIT_READY;
                    end
                end
                MS_WORD_REQ: begin
                    if (word_req) begin
                        if (word_ack) begin
                            word_req <= 1'b0;   // wdata taken this edge
                        end
                    end else if (!word_ack) begin
                        state <= MS_WAIT_READY;
                    end
                end
                MS_WAIT_READY: begin
                    if (ready_sel) begin
                        state <= write_q ? MS_WSHIFT : MS_RSHIFT;
                    end
                end
                MS_WSHIFT: begin
                    bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    if (word_end) begin
                        bit_cnt  <= '0;
                        word_cnt <= word_cnt + len_t'(1);
                        word_req <= !final_word;
                        state    <= final_word ? MS_IDLE : MS_WORD_REQ;
                    end
                end
                MS_RSHIFT: begin
                    bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    if (word_end) begin
                        bit_cnt  <= '0;
                        word_cnt <= word_cnt + len_t'(1);
                        word_req <= 1'b1;   // word complete on this edge
                        state    <= MS_WORD_ACK;
                    end
                end
                MS_WORD_ACK: begin
                    if (word_req) begin
                        if (word_ack) begin
                            word_req <= 1'b0;
                        end
                    end else if (!word_ack) begin
                        state <= (word_cnt == len_q) ? MS_IDLE : MS_WAIT_READY;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // frame and data shifters
    always_ff @(posedge clk) begin
        if (state == MS_IDLE && cmd_req) begin
            frame_q <= {START_CODE, cmd_slave, cmd_write, (cmd_len > len_t'(1)), cmd_addr};
        end else if (state == MS_FRAME) begin
            frame_q <= frame_q << 1;
        end

        if (state == MS_WORD_REQ && word_req && word_ack) begin
            data_q <= wdata;
        end else if (valid) begin
            data_q <= {data_q[DATA_WIDTH-2:0], rd_sel};   // rd sampled with valid
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) $fell(cmd_ack) |-> !$past(cmd_req))
        else $error("cmd_ack fell with cmd_req high");
    assert property (@(posedge clk) disable iff (!resetn) $rose(word_req) |-> !$past(word_ack))
        else $error("word_req rose with word_ack high");
    assert property (@(posedge clk) disable iff (!resetn)
        (state == MS_IDLE && cmd_req) |-> (cmd_len >= len_t'(1) && cmd_len <= len_t'(MAX_BURST)))
        else $error("cmd_len out of range");

endmodule

`default_nettype wire

//--- logic/sbus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial bus widths, frame layout and state types
// frame is 15 bits, MSB first: 111 | id | rw | burst | addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sbus_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int DEPTH       = 256;
    localparam int ADDR_WIDTH  = 8;   // log2 of DEPTH
    localparam int SLAVE_COUNT = 3;   // populated ids 0..2
    localparam int ID_WIDTH    = 2;
    localparam int FRAME_LEN   = 15;
    localparam int MAX_BURST   = 4;

    // frame field positions
    localparam int START_LEN = 3;
    localparam logic [START_LEN-1:0] START_CODE = 3'b111;
    localparam int ID_LSB = ADDR_WIDTH + 2;
    localparam int RW_POS = ADDR_WIDTH + 1;   // 1 = write

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ID_WIDTH-1:0]   slave_id_t;
    typedef logic [FRAME_LEN-1:0]  frame_t;
    typedef logic [5:0]            bit_cnt_t;
    typedef logic [2:0]            len_t;   // 1..MAX_BURST

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_FRAME,
        SL_SKIP,
        SL_WRITE,
        SL_STORE,
        SL_FETCH,
        SL_READ
    } slave_state_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_CMD_ACK,
        MS_FRAME,
        MS_WORD_REQ,
        MS_WSHIFT,
        MS_WAIT_READY,
        MS_RSHIFT,
        MS_WORD_ACK
    } master_state_t;

endpackage

`default_nettype wire

//--- logic/sbus_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial bus slave with its own memory
// id comes from a tie at the top level
// frames for other ids are skipped until last
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sbus_slave
    import sbus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  slave_id_t slave_id,
    input  logic      control,
    input  logic      wd,
    input  logic      valid,
    input  logic      last,
    output logic      rd,
    output logic      ready
);

    slave_state_t state;
    bit_cnt_t     bit_cnt;
    logic         final_q;   // last seen on the word being stored
    frame_t       frame_q;
    frame_t       frame_next;
    addr_t        addr_q;
    word_t        shift_q;
    word_t        ram_rdata;
    logic         frame_end;
    logic         frame_hit;
    logic         word_end;

    assign frame_next = {frame_q[FRAME_LEN-2:0], control};
    assign frame_end  = (bit_cnt == bit_cnt_t'(FRAME_LEN - 1));
    assign word_end   = (bit_cnt == bit_cnt_t'(DATA_WIDTH - 1));
    assign frame_hit  = (frame_next[FRAME_LEN-1 -: START_LEN] == START_CODE) &&
                        (frame_next[ID_LSB +: ID_WIDTH] == slave_id);

    assign ready = !(state == SL_STORE || state == SL_FETCH);
    assign rd    = valid & (state == SL_READ) & shift_q[DATA_WIDTH-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= SL_IDLE;
            bit_cnt <= '0;
            final_q <= 1'b0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (control) begin   // first start bit
                        bit_cnt <= bit_cnt_t'(1);
                        state   <= SL_FRAME;
                    end
                end
                SL_FRAME: begin
                    bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    if (frame_end) begin
                        bit_cnt <= '0;
                        if (!frame_hit) begin
                            state <= SL_SKIP;
                        end else if (frame_next[RW_POS]) begin
                            state <= SL_WRITE;
                        end else begin
                            state <= SL_FETCH;
                        end
                    end
                end
                SL_SKIP: begin
                    if (last) begin
                        state <= SL_IDLE;
                    end
                end
                SL_WRITE: begin
                    if (valid) begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                        if (word_end) begin
                            bit_cnt <= '0;
                            final_q <= last;
                            state   <= SL_STORE;
                        end
                    end
                end
                SL_STORE: state <= final_q ? SL_IDLE : SL_WRITE;
                SL_FETCH: state <= SL_READ;
                SL_READ: begin
                    if (valid) begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                        if (word_end) begin
                            bit_cnt <= '0;
                            state   <= last ? SL_IDLE : SL_FETCH;
                        end
                    end
                end
                default: state <= SL_IDLE;
            endcase
        end
    end

    // frame, address and data shifter
    always_ff @(posedge clk) begin
        if (state == SL_IDLE || state == SL_FRAME) begin
            frame_q <= frame_next;
        end

        if (state == SL_FRAME && frame_end) begin
            addr_q <= frame_next[ADDR_WIDTH-1:0];
        end else if (state == SL_STORE || (state == SL_READ && valid && word_end)) begin
            addr_q <= addr_q + addr_t'(1);   // wraps at DEPTH
        end

        if (state == SL_WRITE && valid) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], wd};
        end else if (state == SL_READ) begin
            if (valid) begin
                shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
            end else if (bit_cnt == '0) begin
                shift_q <= ram_rdata;   // fetched word, before first bit
            end
        end
    end

    word_ram word_ram_inst (
        .clk   (clk),
        .we    (state == SL_STORE),
        .addr  (addr_q),
        .wdata (shift_q),
        .rdata (ram_rdata)
    );

    // master must honour the one-cycle stall
    assert property (@(posedge clk) disable iff (!resetn) !ready |=> ready)
        else $error("ready low for more than one cycle");
    assert property (@(posedge clk) disable iff (!resetn) !ready |-> !valid)
        else $error("valid while slave not ready");
    assert property (@(posedge clk) disable iff (!resetn) last |-> valid)
        else $error("last without valid");

endmodule

`default_nettype wire

//--- logic/sbus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// master and three slaves on one serial bus
// id 3 has no slave behind it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sbus_top
    import sbus_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      cmd_req,
    input  logic      cmd_write,
    input  slave_id_t cmd_slave,
    input  addr_t     cmd_addr,
    input  len_t      cmd_len,
    output logic      cmd_ack,
    output logic      word_req,
    input  logic      word_ack,
    input  word_t     wdata,
    output word_t     rdata
);

    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd0;
    logic rd1;
    logic rd2;
    logic ready0;
    logic ready1;
    logic ready2;

    sbus_master sbus_master_inst (
        .clk       (clk),
        .resetn    (resetn),
        .cmd_req   (cmd_req),
        .cmd_write (cmd_write),
        .cmd_slave (cmd_slave),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .cmd_ack   (cmd_ack),
        .word_req  (word_req),
        .word_ack  (word_ack),
        .wdata     (wdata),
        .rdata     (rdata),
        .control   (control),
        .wd        (wd),
        .valid     (valid),
        .last      (last),
        .rd0       (rd0),
        .rd1       (rd1),
        .rd2       (rd2),
        .ready0    (ready0),
        .ready1    (ready1),
        .ready2    (ready2)
    );

    sbus_slave sbus_slave0_inst (
        .clk      (clk),
        .resetn   (resetn),
        .slave_id (slave_id_t'(0)),
        .control  (control),
        .wd       (wd),
        .valid    (valid),
        .last     (last),
        .rd       (rd0),
        .ready    (ready0)
    );

    sbus_slave sbus_slave1_inst (
        .clk      (clk),
        .resetn   (resetn),
        .slave_id (slave_id_t'(1)),
        .control  (control),
        .wd       (wd),
        .valid    (valid),
        .last     (last),
        .rd       (rd1),
        .ready    (ready1)
    );

    sbus_slave sbus_slave2_inst (
        .clk      (clk),
        .resetn   (resetn),
        .slave_id (slave_id_t'(2)),
        .control  (control),
        .wd       (wd),
        .valid    (valid),
        .last     (last),
        .rd       (rd2),
        .ready    (ready2)
    );

endmodule

`default_nettype wire

//--- logic/word_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single port RAM, write wins over read
// read data appears one cycle after addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module word_ram
    import sbus_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];   // registered read
        end
    end

endmodule

`default_nettype wire

//--- sbus.f
logic/sbus_pkg.sv
logic/word_ram.sv
logic/sbus_slave.sv
logic/sbus_master.sv
logic/sbus_top.sv
tb/sbus_tb.sv

//--- tb/sbus_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host-side testbench for the serial bus
// only addresses written earlier are read back
// id 3 is modeled as absent and reads as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sbus_tb
    import sbus_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 20 * MAX_BURST * 60 + 2000;

    logic      clk;
    logic      resetn;
    logic      cmd_req;
    logic      cmd_write;
    slave_id_t cmd_slave;
    addr_t     cmd_addr;
    len_t      cmd_len;
    logic      cmd_ack;
    logic      word_req;
    logic      word_ack;
    word_t     wdata;
    word_t     rdata;

    word_t       model [1 << ID_WIDTH][DEPTH];   // row 3 stays zero
    logic        cur_write = 1'b0;
    word_t       expected_word = '0;
    int unsigned lcg_state = 88;
    int          cycle_count = 0;

    sbus_top sbus_top_inst (
        .clk       (clk),
        .resetn    (resetn),
        .cmd_req   (cmd_req),
        .cmd_write (cmd_write),
        .cmd_slave (cmd_slave),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .cmd_ack   (cmd_ack),
        .word_req  (word_req),
        .word_ack  (word_ack),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: transactions did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;   // upper bits are the better ones
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic command(input logic write, input slave_id_t id, input addr_t addr,
                           input len_t len);
        cur_write = write;
        repeat (lcg_next() % 4) next_cycle();   // random host stall
        cmd_write = write;
        cmd_slave = id;
        cmd_addr  = addr;
        cmd_len   = len;
        cmd_req   = 1'b1;
        do next_cycle(); while (!cmd_ack);
        repeat (lcg_next() % 4) next_cycle();
        cmd_req = 1'b0;
        do next_cycle(); while (cmd_ack);
    endtask

    task automatic word_handshake(input word_t data);
        do next_cycle(); while (!word_req);
        repeat (lcg_next() % 4) next_cycle();   // late word_ack
        wdata    = data;
        word_ack = 1'b1;
        do next_cycle(); while (word_req);
        word_ack = 1'b0;
    endtask

    task automatic write_burst(input slave_id_t id, input addr_t addr, input len_t len);
        word_t data;
        addr_t a;
        int    i;
        command(1'b1, id, addr, len);
        for (i = 0; i < int'(len); i++) begin
            data = (lcg_next() << 16) ^ lcg_next();
            a    = addr_t'((int'(addr) + i) % DEPTH);   // wraps in memory
            if (id < slave_id_t'(SLAVE_COUNT)) begin
                model[id][a] = data;
            end
            word_handshake(data);
        end
    endtask

    task automatic read_burst(input slave_id_t id, input addr_t addr, input len_t len);
        int i;
        command(1'b0, id, addr, len);
        for (i = 0; i < int'(len); i++) begin
            expected_word = model[id][addr_t'((int'(addr) + i) % DEPTH)];
            word_handshake('0);
        end
    endtask

    // handshake rules and read data
    assert property (@(posedge clk) !resetn |-> (!cmd_ack && !word_req))
        else report_error("cmd_ack or word_req active during reset");
    assert property (@(posedge clk) disable iff (!resetn) $rose(cmd_ack) |-> $past(cmd_req))
        else report_error("cmd_ack rose without cmd_req");
    assert property (@(posedge clk) disable iff (!resetn) $fell(cmd_ack) |-> !$past(cmd_req))
        else report_error("cmd_ack fell while cmd_req was high");
    assert property (@(posedge clk) disable iff (!resetn) $rose(word_req) |-> !$past(word_ack))
        else report_error("word_req rose while word_ack was high");
    assert property (@(posedge clk) disable iff (!resetn) $fell(word_req) |-> $past(word_ack))
        else report_error("word_req fell without word_ack");
    assert property (@(posedge clk) disable iff (!resetn)
        ($rose(word_req) && !cur_write) |-> (rdata == expected_word))
        else report_error($sformatf("rdata %h, expected %h", rdata, expected_word));
    assert property (@(posedge clk) disable iff (!resetn)
        (word_req && !cur_write) |=> $stable(rdata))
        else report_error("rdata changed during the word handshake");

    initial begin
        int s;
        int a;
        int i;
        resetn    = 1'b0;
        cmd_req   = 1'b0;
        cmd_write = 1'b0;
        cmd_slave = '0;
        cmd_addr  = '0;
        cmd_len   = len_t'(1);
        word_ack  = 1'b0;
        wdata     = '0;
        for (s = 0; s < (1 << ID_WIDTH); s++) begin
            for (a = 0; a < DEPTH; a++) begin
                model[s][a] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        next_cycle();

        // single words, same address in every slave
        for (s = 0; s < SLAVE_COUNT; s++) write_burst(slave_id_t'(s), addr_t'(16), len_t'(1));
        for (s = 0; s < SLAVE_COUNT; s++) read_burst(slave_id_t'(s), addr_t'(16), len_t'(1));
        write_burst(slave_id_t'(1), addr_t'(16), len_t'(1));   // others must keep theirs
        read_burst(slave_id_t'(0), addr_t'(16), len_t'(1));
        read_burst(slave_id_t'(2), addr_t'(16), len_t'(1));
        read_burst(slave_id_t'(1), addr_t'(16), len_t'(1));

        // bursts of 2, 3 and 4 words
        for (s = 2; s <= MAX_BURST; s++) begin
            write_burst(slave_id_t'(s - 2), addr_t'(32 * s), len_t'(s));
        end
        for (s = 2; s <= MAX_BURST; s++) begin
            for (i = 0; i < s; i++) begin
                read_burst(slave_id_t'(s - 2), addr_t'(32 * s + i), len_t'(1));
            end
            read_burst(slave_id_t'(s - 2), addr_t'(32 * s), len_t'(s));
        end

        // address wrap past the top of memory
        write_burst(slave_id_t'(2), addr_t'(254), len_t'(4));
        read_burst(slave_id_t'(2), addr_t'(254), len_t'(4));
        read_burst(slave_id_t'(2), addr_t'(0), len_t'(1));
        read_burst(slave_id_t'(2), addr_t'(1), len_t'(1));

        // unpopulated id 3
        write_burst(slave_id_t'(3), addr_t'(16), len_t'(2));
        read_burst(slave_id_t'(3), addr_t'(16), len_t'(2));
        for (s = 0; s < SLAVE_COUNT; s++) read_burst(slave_id_t'(s), addr_t'(16), len_t'(1));

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
